// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = scurveTestTb
FILELIST = project.f
BUILD    = obj_dir
PASS_MSG = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD)

// ==== design/hitFifo.sv ====
`timescale 1ns/1ps
`include "scurve_params.svh"

// First-word-fall-through buffer for trigger counts
module hitFifo #(
  parameter int depth = `FIFO_DEPTH
) (
  input  logic                  Clk,
  input  logic                  reset_n,
  input  logic                  writeEnable,
  input  scurve_pkg::dataWord_t writeData,
  input  logic                  readEnable,
  output scurve_pkg::dataWord_t readData,
  output logic                  empty,
  output logic                  full
);

  import scurve_pkg::*;

  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntW = $clog2(depth + 1);

  dataWord_t       mem [depth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] wordCount;
  logic            doWrite;
  logic            doRead;

  // Pointer increment with wrap for any depth
  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
    if (ptr == ptrW'(depth - 1)) begin
      nextPtr = '0;
    end else begin
      nextPtr = ptr + 1'b1;
    end
  endfunction

  assign doWrite  = writeEnable && !full;  // Write to a full buffer is lost
  assign doRead   = readEnable && !empty;
  assign empty    = (wordCount == '0);
  assign full     = (wordCount == cntW'(depth));
  assign readData = mem[rdPtr];            // Head word always on the output

  always_ff @(posedge Clk) begin
    if (doWrite) begin
      mem[wrPtr] <= writeData;
    end
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      wordCount <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doRead) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({doWrite, doRead})
        2'b10:   wordCount <= wordCount + 1'b1;
        2'b01:   wordCount <= wordCount - 1'b1;
        default: wordCount <= wordCount;  // Idle or simultaneous push and pop
      endcase
    end
  end

endmodule

// ==== design/scurveTestControl.sv ====
`timescale 1ns/1ps
`include "scurve_params.svh"

// S-curve scan sequencer and stream framer
module scurveTestControl (
  input  logic                   Clk,
  input  logic                   reset_n,
  input  logic                   testStart,
  // Scan settings
  input  logic                   singleChannel,
  input  scurve_pkg::chnIndex_t  testChannel,
  input  logic                   ctestInject,
  input  scurve_pkg::dacCode_t   startDac,
  input  scurve_pkg::dacCode_t   endDac,
  input  scurve_pkg::dacCode_t   dacStep,
  input  scurve_pkg::asicCount_t asicNumber,
  input  scurve_pkg::asicCount_t testAsicNumber,
  input  logic                   unmaskAll,
  // ASIC slow control
  output logic [63:0]            ctestChannels,
  output scurve_pkg::dacCode_t   dacOut,
  output logic [191:0]           discriMask,
  output logic                   forceExtRaz,
  output logic                   configLoadStart,
  input  logic                   configDone,
  // Output stream
  output scurve_pkg::dataWord_t  dataOut,
  output logic                   dataOutEnable,
  input  logic                   usbFifoFull,
  output logic                   scanDone,
  input  logic                   transmitDone,
  // Trigger counter and count buffer
  output logic                   singleTestStart,
  input  logic                   singleTestDone,
  output logic                   readEnable,
  input  scurve_pkg::dataWord_t  readData,
  input  logic                   empty
);

  import scurve_pkg::*;

  localparam int settleW = $clog2(`SC_SETTLE_CYCLES + 1);

  localparam logic [7:0]   chnTagSingle = 8'h43;    // "C"
  localparam logic [7:0]   chnTagAll    = 8'h63;    // "c"
  localparam logic [3:0]   dacTag       = 4'hD;
  localparam dataWord_t    unmaskWord   = 16'h43FF;
  localparam logic [191:0] chnMaskUnit  = 192'h7;   // Three discriminators per channel

  scanState_t         scanState;
  dacCode_t           dacCode;
  chnIndex_t          testChn;
  asicCount_t         loadCount;
  asicCount_t         testLoadIndex;
  logic [settleW-1:0] settleCount;
  logic [191:0]       maskInternal;

  // The ASIC nearest the end of the chain is loaded first
  assign testLoadIndex = asicNumber - testAsicNumber - 3'd1;

  // Slow control expects the DAC code LSB first
  function automatic dacCode_t reverseDac(input dacCode_t code);
    dacCode_t result;
    for (int i = 0; i < $bits(dacCode_t); i++) begin
      result[i] = code[$bits(dacCode_t) - 1 - i];
    end
    return result;
  endfunction

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      scanState       <= Idle;
      dacCode         <= '0;
      testChn         <= '0;
      loadCount       <= '0;
      settleCount     <= '0;
      maskInternal    <= '0;
      ctestChannels   <= '0;
      dacOut          <= '0;
      discriMask      <= '0;
      forceExtRaz     <= 1'b0;
      configLoadStart <= 1'b0;
      dataOut         <= '0;
      dataOutEnable   <= 1'b0;
      scanDone        <= 1'b0;
      singleTestStart <= 1'b0;
      readEnable      <= 1'b0;
    end else begin
      // Strobes default low so each lasts one cycle
      dataOutEnable   <= 1'b0;
      configLoadStart <= 1'b0;
      singleTestStart <= 1'b0;
      readEnable      <= 1'b0;

      case (scanState)
        Idle: begin
          if (testStart) begin
            dacCode   <= startDac;
            testChn   <= singleChannel ? testChannel : chnIndex_t'(0);
            loadCount <= '0;
            scanState <= HeaderOut;
          end
        end

        HeaderOut: begin
          dataOut       <= `SCURVE_HEADER;
          dataOutEnable <= 1'b1;
          scanState     <= ChannelSet;
        end

        ChannelSet: begin
          if (unmaskAll) begin
            ctestChannels <= 64'd1 << testChannel;
            maskInternal  <= '1;              // Every discriminator open
            dataOut       <= unmaskWord;
          end else begin
            ctestChannels <= ctestInject ? (64'd1 << testChn) : 64'd0;
            maskInternal  <= chnMaskUnit << (8'd3 * 8'(testChn));
            dataOut       <= {(singleChannel ? chnTagSingle : chnTagAll), 2'b00, testChn};
          end
          scanState <= ChannelOut;
        end

        ChannelOut: begin
          dataOutEnable <= 1'b1;
          scanState     <= DacSet;
        end

        DacSet: begin
          dacOut    <= reverseDac(dacCode);
          dataOut   <= {dacTag, 2'b00, dacCode};
          scanState <= DacOut;
        end

        DacOut: begin
          dataOutEnable <= 1'b1;
          scanState     <= MaskSelect;
        end

        ////////////////////////////////////////////////////////////
        // Chain load, one pass per ASIC

        MaskSelect: begin
          // Only the ASIC under test sees the open mask
          discriMask <= (loadCount == testLoadIndex) ? maskInternal : 192'd0;
          scanState  <= LoadParam;
        end

        LoadParam: begin
          if (loadCount < asicNumber) begin
            configLoadStart <= 1'b1;
            forceExtRaz     <= 1'b1;
            loadCount       <= loadCount + 1'b1;
            scanState       <= WaitConfig;
          end else begin
            loadCount <= '0;
            scanState <= TestStart;
          end
        end

        WaitConfig: begin
          if (configDone) begin
            settleCount <= '0;
            scanState   <= Settle;
          end
        end

        Settle: begin
          if (settleCount == settleW'(`SC_SETTLE_CYCLES - 1)) begin
            forceExtRaz <= 1'b0;
            scanState   <= MaskSelect;    // Next ASIC, or start when all loaded
          end else begin
            settleCount <= settleCount + 1'b1;
          end
        end

        ////////////////////////////////////////////////////////////
        // Counting window and count drain

        TestStart: begin
          singleTestStart <= 1'b1;
          scanState       <= TestWait;
        end

        TestWait: begin
          if (singleTestDone) begin
            scanState <= DrainCheck;
          end
        end

        DrainCheck: begin
          if (empty) begin
            scanState <= StepCheck;
          end else begin
            readEnable <= 1'b1;           // Pops the head word next cycle
            scanState  <= DrainRead;
          end
        end

        DrainRead: begin
          dataOut   <= readData;
          scanState <= CountOut;
        end

        CountOut: begin
          if (!usbFifoFull) begin         // Hold the count while USB side is full
            dataOutEnable <= 1'b1;
            scanState     <= DrainCheck;
          end
        end

        ////////////////////////////////////////////////////////////
        // Scan progress and end of stream

        StepCheck: begin
          if (dacCode == endDac) begin
            dacCode   <= startDac;
            scanState <= ChannelCheck;
          end else begin
            dacCode   <= dacCode + dacStep;
            scanState <= DacSet;
          end
        end

        ChannelCheck: begin
          if (singleChannel || (testChn == 6'd63)) begin
            dataOut   <= `SCURVE_TAIL;
            scanState <= TailOut;
          end else begin
            testChn   <= testChn + 1'b1;
            scanState <= ChannelSet;
          end
        end

        TailOut: begin
          dataOutEnable <= 1'b1;
          scanDone      <= 1'b1;
          scanState     <= DoneHold;
        end

        DoneHold: begin
          if (transmitDone) begin         // Downstream has taken the stream
            scanDone  <= 1'b0;
            scanState <= Idle;
          end
        end

        default: scanState <= Idle;
      endcase
    end
  end

endmodule

// ==== design/scurveTestTop.sv ====
`timescale 1ns/1ps
`include "scurve_params.svh"

// S-curve scan subsystem: counter, count buffer and sequencer
module scurveTestTop (
  input  logic                   Clk,
  input  logic                   reset_n,
  input  logic                   testStart,
  input  logic                   singleChannel,
  input  scurve_pkg::chnIndex_t  testChannel,
  input  logic                   ctestInject,
  input  scurve_pkg::dacCode_t   startDac,
  input  scurve_pkg::dacCode_t   endDac,
  input  scurve_pkg::dacCode_t   dacStep,
  input  scurve_pkg::asicCount_t asicNumber,
  input  scurve_pkg::asicCount_t testAsicNumber,
  input  logic                   unmaskAll,
  input  logic                   configDone,
  input  logic                   trigger,
  input  logic                   usbFifoFull,
  input  logic                   transmitDone,
  output logic [63:0]            ctestChannels,
  output scurve_pkg::dacCode_t   dacOut,
  output logic [191:0]           discriMask,
  output logic                   forceExtRaz,
  output logic                   configLoadStart,
  output scurve_pkg::dataWord_t  dataOut,
  output logic                   dataOutEnable,
  output logic                   scanDone
);

  import scurve_pkg::*;

  logic      singleTestStart;
  logic      singleTestDone;
  logic      writeEnable;
  dataWord_t writeData;
  logic      readEnable;
  dataWord_t readData;
  logic      empty;

  ////////////////////////////////////////////////////////////
  // Producer, buffer, consumer
  ////////////////////////////////////////////////////////////

  triggerCounter u_triggerCounter (
    .Clk             (Clk),
    .reset_n         (reset_n),
    .singleTestStart (singleTestStart),
    .trigger         (trigger),
    .singleTestDone  (singleTestDone),
    .writeEnable     (writeEnable),
    .writeData       (writeData)
  );

  hitFifo #(
    .depth (`FIFO_DEPTH)
  ) u_hitFifo (
    .Clk         (Clk),
    .reset_n     (reset_n),
    .writeEnable (writeEnable),
    .writeData   (writeData),
    .readEnable  (readEnable),
    .readData    (readData),
    .empty       (empty),
    .full        ()
  );

  scurveTestControl u_scurveTestControl (
    .Clk             (Clk),
    .reset_n         (reset_n),
    .testStart       (testStart),
    .singleChannel   (singleChannel),
    .testChannel     (testChannel),
    .ctestInject     (ctestInject),
    .startDac        (startDac),
    .endDac          (endDac),
    .dacStep         (dacStep),
    .asicNumber      (asicNumber),
    .testAsicNumber  (testAsicNumber),
    .unmaskAll       (unmaskAll),
    .ctestChannels   (ctestChannels),
    .dacOut          (dacOut),
    .discriMask      (discriMask),
    .forceExtRaz     (forceExtRaz),
    .configLoadStart (configLoadStart),
    .configDone      (configDone),
    .dataOut         (dataOut),
    .dataOutEnable   (dataOutEnable),
    .usbFifoFull     (usbFifoFull),
    .scanDone        (scanDone),
    .transmitDone    (transmitDone),
    .singleTestStart (singleTestStart),
    .singleTestDone  (singleTestDone),
    .readEnable      (readEnable),
    .readData        (readData),
    .empty           (empty)
  );

endmodule

// ==== design/scurve_params.svh ====
`ifndef SCURVE_PARAMS_SVH
`define SCURVE_PARAMS_SVH

////////////////////////////////////////////////////////////
// Count buffer
////////////////////////////////////////////////////////////

`define FIFO_DEPTH 8          // Words between trigger counter and controller

////////////////////////////////////////////////////////////
// Scan timing, in clock cycles
////////////////////////////////////////////////////////////

// Trigger counting window opened by each single test start
`define TRIGGER_WINDOW 64
`define SC_SETTLE_CYCLES 16   // Quiet time after each ASIC configuration

////////////////////////////////////////////////////////////
// Stream frame words
////////////////////////////////////////////////////////////

`define SCURVE_HEADER 16'h5343  // ASCII "SC"
`define SCURVE_TAIL 16'hFF45

`endif

// ==== design/scurve_pkg.sv ====
package scurve_pkg;

  typedef logic [15:0] dataWord_t;   // Stream word and trigger count
  typedef logic [9:0]  dacCode_t;    // Threshold DAC code
  typedef logic [5:0]  chnIndex_t;   // Channel within one ASIC
  typedef logic [2:0]  asicCount_t;  // Chain length or chain position

  // Scan sequencer states
  typedef enum logic [4:0] {
    Idle,
    HeaderOut,
    ChannelSet,
    ChannelOut,
    DacSet,
    DacOut,
    MaskSelect,
    LoadParam,
    WaitConfig,
    Settle,
    TestStart,
    TestWait,
    DrainCheck,
    DrainRead,
    CountOut,
    StepCheck,
    ChannelCheck,
    TailOut,
    DoneHold
  } scanState_t;

endpackage

// ==== design/triggerCounter.sv ====
`timescale 1ns/1ps
`include "scurve_params.svh"

// Windowed trigger counter, one count word per single test start
module triggerCounter (
  input  logic                  Clk,
  input  logic                  reset_n,
  input  logic                  singleTestStart,
  input  logic                  trigger,
  output logic                  singleTestDone,
  output logic                  writeEnable,
  output scurve_pkg::dataWord_t writeData
);

  import scurve_pkg::*;

  localparam int timerW = $clog2(`TRIGGER_WINDOW);

  logic              windowOpen;
  logic [timerW-1:0] windowTimer;
  logic              lastCycle;
  dataWord_t         hitCount;
  dataWord_t         hitCountNext;

  ////////////////////////////////////////////////////////////
  // Window timing and saturating count
  ////////////////////////////////////////////////////////////

  assign lastCycle = (windowTimer == timerW'(`TRIGGER_WINDOW - 1));

  always_comb begin
    hitCountNext = hitCount;
    if (trigger && (hitCount != '1)) begin  // Hold at full scale
      hitCountNext = hitCount + 16'd1;
    end
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      windowOpen     <= 1'b0;
      windowTimer    <= '0;
      hitCount       <= '0;
      writeEnable    <= 1'b0;
      singleTestDone <= 1'b0;
    end else begin
      writeEnable    <= 1'b0;
      singleTestDone <= 1'b0;
      if (windowOpen) begin
        hitCount    <= hitCountNext;
        windowTimer <= windowTimer + 1'b1;
        if (lastCycle) begin
          // Count is final in the cycle after the window
          windowOpen     <= 1'b0;
          writeEnable    <= 1'b1;
          singleTestDone <= 1'b1;
        end
      end else if (singleTestStart) begin  // Starts inside a window are dropped
        windowOpen  <= 1'b1;
        windowTimer <= '0;
        hitCount    <= '0;
      end
    end
  end

  assign writeData = hitCount;  // Valid while writeEnable is high

endmodule

// ==== project.f ====
+incdir+design
design/scurve_pkg.sv
design/triggerCounter.sv
design/hitFifo.sv
design/scurveTestControl.sv
design/scurveTestTop.sv
verification/scurveTestChk.sv
verification/scurveTestTb.sv

// ==== verification/scurveTestChk.sv ====
`timescale 1ns/1ps

// Protocol checks on the scan controller strobes and levels
module scurveTestChk (
  input logic Clk,
  input logic reset_n,
  input logic configLoadStart,
  input logic dataOutEnable,
  input logic scanDone,
  input logic transmitDone,
  input logic readEnable,
  input logic empty
);

  ////////////////////////////////////////////////////////////
  // Strobe widths
  ////////////////////////////////////////////////////////////

  loadPulseWidth: assert property (@(posedge Clk) disable iff (!reset_n)
    configLoadStart |=> !configLoadStart)
    else $error("configLoadStart held longer than one cycle");

  outPulseWidth: assert property (@(posedge Clk) disable iff (!reset_n)
    dataOutEnable |=> !dataOutEnable)
    else $error("dataOutEnable held longer than one cycle");

  ////////////////////////////////////////////////////////////
  // Done handshake and buffer reads
  ////////////////////////////////////////////////////////////

  doneRelease: assert property (@(posedge Clk) disable iff (!reset_n)
    $fell(scanDone) |-> $past(transmitDone))
    else $error("scanDone fell without transmitDone");

  readWhenEmpty: assert property (@(posedge Clk) disable iff (!reset_n)
    !(readEnable && empty))
    else $error("Count buffer read while empty");

endmodule

bind scurveTestControl scurveTestChk u_scurveTestChk (
  .Clk             (Clk),
  .reset_n         (reset_n),
  .configLoadStart (configLoadStart),
  .dataOutEnable   (dataOutEnable),
  .scanDone        (scanDone),
  .transmitDone    (transmitDone),
  .readEnable      (readEnable),
  .empty           (empty)
);

// ==== verification/scurveTestTb.sv ====
`timescale 1ns/1ps
`include "scurve_params.svh"

module scurveTestTb;

  import scurve_pkg::*;

  localparam time clkPeriod   = 40ns;
  localparam int  resetCycles = 8;
  localparam int  totalSteps  = 77;   // DAC steps summed over all scans below
  localparam int  stepBudget  = `TRIGGER_WINDOW + `SC_SETTLE_CYCLES + 200;

  logic         Clk;
  logic         reset_n;
  logic         testStart;
  logic         singleChannel;
  chnIndex_t    testChannel;
  logic         ctestInject;
  dacCode_t     startDac;
  dacCode_t     endDac;
  dacCode_t     dacStep;
  asicCount_t   asicNumber;
  asicCount_t   testAsicNumber;
  logic         unmaskAll;
  logic         configDone;
  logic         trigger;
  logic         usbFifoFull;
  logic         transmitDone;
  logic [63:0]  ctestChannels;
  dacCode_t     dacOut;
  logic [191:0] discriMask;
  logic         forceExtRaz;
  logic         configLoadStart;
  dataWord_t    dataOut;
  logic         dataOutEnable;
  logic         scanDone;

  logic [15:0]  lfsr;
  logic         fullSeen;     // usbFifoFull as the DUT saw it at the last edge
  dataWord_t    gotWords[$];
  dataWord_t    expWords[$];
  int           drawnCounts[$];
  logic [191:0] loadMasks[$];
  dacCode_t     loadDacs[$];
  logic [63:0]  loadCtest[$];
  int           errCount;
  int           testsRun;
  int           testsFailed;

  scurveTestTop u_scurveTestTop (.*);

  initial begin
    Clk = 1'b0;
    forever #(clkPeriod / 2) Clk = ~Clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic nextBit();
    logic outBit;
    outBit = lfsr[0];
    lfsr   = (lfsr >> 1) ^ (outBit ? 16'hB400 : 16'h0000);
    return outBit;
  endfunction

  function automatic int drawCount();
    int value;
    value = 0;
    for (int i = 0; i < 4; i++) begin
      value = value | (int'(nextBit()) << i);
    end
    return value;
  endfunction

  function automatic dacCode_t bitReverse(input dacCode_t code);
    dacCode_t flipped;
    for (int i = 0; i < 10; i++) begin
      flipped[9 - i] = code[i];
    end
    return flipped;
  endfunction

  task automatic reportFailure(input string what);
    $display("%s", what);
    errCount++;
  endtask

  task automatic checkValue(input string name, input logic [191:0] expected,
                            input logic [191:0] actual);
    assert (expected == actual) else begin
      $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
      errCount++;
    end
  endtask

  task automatic clearRecords();
    gotWords.delete();
    drawnCounts.delete();
    loadMasks.delete();
    loadDacs.delete();
    loadCtest.delete();
  endtask

  task automatic setupScan(input logic single, input chnIndex_t chn, input logic inject,
                           input dacCode_t first, input dacCode_t last, input dacCode_t step,
                           input asicCount_t asics, input asicCount_t testAsic,
                           input logic unmask);
    @(posedge Clk);
    singleChannel  <= single;
    testChannel    <= chn;
    ctestInject    <= inject;
    startDac       <= first;
    endDac         <= last;
    dacStep        <= step;
    asicNumber     <= asics;
    testAsicNumber <= testAsic;
    unmaskAll      <= unmask;
    clearRecords();
  endtask

  // Start one scan, hold off the acknowledge, then release scanDone
  task automatic runScan(input int holdCycles);
    @(posedge Clk);
    testStart <= 1'b1;
    @(posedge Clk);
    testStart <= 1'b0;
    @(negedge Clk);
    while (!scanDone) @(negedge Clk);
    repeat (holdCycles) begin
      @(negedge Clk);
      assert (scanDone) else reportFailure("scanDone fell before transmitDone");
    end
    @(posedge Clk);
    transmitDone <= 1'b1;
    @(posedge Clk);
    transmitDone <= 1'b0;
    @(negedge Clk);
    assert (!scanDone) else reportFailure("scanDone still high after transmitDone");
  endtask

  // Expected frame from the scan settings and the drawn trigger counts
  task automatic buildExpected();
    int        nSteps;
    int        nextCount;
    int        firstChn;
    int        lastChn;
    dataWord_t chnWord;
    expWords.delete();
    nSteps    = (int'(endDac) - int'(startDac)) / int'(dacStep) + 1;
    nextCount = 0;
    firstChn  = singleChannel ? int'(testChannel) : 0;
    lastChn   = singleChannel ? int'(testChannel) : 63;
    expWords.push_back(`SCURVE_HEADER);
    for (int c = firstChn; c <= lastChn; c++) begin
      if (unmaskAll) begin
        chnWord = 16'h43FF;
      end else begin
        chnWord = {(singleChannel ? 8'h43 : 8'h63), 2'b00, 6'(c)};
      end
      expWords.push_back(chnWord);
      for (int s = 0; s < nSteps; s++) begin
        expWords.push_back({4'hD, 2'b00, 10'(int'(startDac) + s * int'(dacStep))});
        if (nextCount < drawnCounts.size()) begin
          expWords.push_back(16'(drawnCounts[nextCount]));
        end else begin
          expWords.push_back(16'hFFFF);   // No window was run for this step
        end
        nextCount++;
      end
    end
    expWords.push_back(`SCURVE_TAIL);
  endtask

  task automatic compareStream(input string name);
    buildExpected();
    checkValue($sformatf("%s stream length", name), 192'(expWords.size()),
               192'(gotWords.size()));
    for (int i = 0; i < expWords.size() && i < gotWords.size(); i++) begin
      checkValue($sformatf("%s word %0d", name, i), 192'(expWords[i]), 192'(gotWords[i]));
    end
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    testsRun++;
    if (errCount == errorsBefore) begin
      $display("%s done, no errors", name);
    end else begin
      testsFailed++;
      $display("%s done, %0d errors", name, errCount - errorsBefore);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus and monitors
  ////////////////////////////////////////////////////////////

  // Trigger pulses in the middle of each counting window
  always begin
    int hits;
    @(negedge Clk);
    if (u_scurveTestTop.singleTestStart) begin
      hits = drawCount();
      drawnCounts.push_back(hits);
      repeat (16) @(posedge Clk);
      repeat (hits) begin
        trigger <= 1'b1;
        @(posedge Clk);
        trigger <= 1'b0;
        @(posedge Clk);
      end
    end
  end

  // ASIC chain model, answers each load and watches forceExtRaz
  always begin
    @(negedge Clk);
    if (configLoadStart) begin
      loadMasks.push_back(discriMask);
      loadDacs.push_back(dacOut);
      loadCtest.push_back(ctestChannels);
      assert (forceExtRaz) else reportFailure("forceExtRaz low at a configuration load");
      repeat (3) @(posedge Clk);
      configDone <= 1'b1;
      @(posedge Clk);
      configDone <= 1'b0;
      repeat (`SC_SETTLE_CYCLES) begin
        @(negedge Clk);
        assert (forceExtRaz) else reportFailure("forceExtRaz fell before the settle delay");
      end
      @(negedge Clk);
      assert (!forceExtRaz) else reportFailure("forceExtRaz still high after the settle delay");
    end
  end

  always @(negedge Clk) begin
    if (dataOutEnable) begin
      gotWords.push_back(dataOut);
      if (dataOut[15:12] == 4'h0) begin  // Counts are the only words with a zero top nibble
        assert (!fullSeen) else reportFailure("Count word sent while usbFifoFull was high");
      end
    end
    fullSeen = usbFifoFull;
  end

  // Stall each count word for a while, then let it through
  task automatic holdFull(input int steps);
    @(posedge Clk);
    usbFifoFull <= 1'b1;
    repeat (steps) begin
      @(negedge Clk);
      while (u_scurveTestTop.u_scurveTestControl.scanState != CountOut) @(negedge Clk);
      repeat (10) @(posedge Clk);
      usbFifoFull <= 1'b0;
      @(posedge Clk);
      usbFifoFull <= 1'b1;
    end
    usbFifoFull <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic singleScanTest();
    int errorsBefore;
    errorsBefore = errCount;
    setupScan(1'b1, 6'd21, 1'b1, 10'd100, 10'd140, 10'd20, 3'd1, 3'd0, 1'b0);
    runScan(0);
    compareStream("singleScan");
    checkValue("singleScan load count", 192'(3), 192'(loadDacs.size()));
    for (int i = 0; i < loadDacs.size(); i++) begin
      checkValue("singleScan dacOut", 192'(bitReverse(10'(100 + 20 * i))), 192'(loadDacs[i]));
      checkValue("singleScan ctestChannels", 192'(64'd1 << 21), 192'(loadCtest[i]));
    end
    finishTest("singleScan", errorsBefore);
  endtask

  task automatic chainMaskTest();
    int errorsBefore;
    errorsBefore = errCount;
    setupScan(1'b1, 6'd9, 1'b0, 10'd200, 10'd210, 10'd10, 3'd4, 3'd1, 1'b0);
    runScan(0);
    compareStream("chainMask");
    checkValue("chainMask load count", 192'(8), 192'(loadMasks.size()));
    for (int i = 0; i < loadMasks.size(); i++) begin
      checkValue($sformatf("chainMask load %0d mask", i),
                 (i % 4 == 2) ? (192'h7 << 27) : 192'd0, loadMasks[i]);
    end
    finishTest("chainMask", errorsBefore);
  endtask

  task automatic allChannelTest();
    int errorsBefore;
    errorsBefore = errCount;
    setupScan(1'b0, 6'd5, 1'b0, 10'd300, 10'd300, 10'd1, 3'd1, 3'd0, 1'b0);
    runScan(0);
    compareStream("allChannels");
    checkValue("allChannels load count", 192'(64), 192'(loadMasks.size()));
    for (int i = 0; i < loadMasks.size(); i++) begin
      checkValue("allChannels mask", 192'h7 << (3 * i), loadMasks[i]);
      checkValue("allChannels ctestChannels", 192'd0, 192'(loadCtest[i]));
      checkValue("allChannels dacOut", 192'(bitReverse(10'd300)), 192'(loadDacs[i]));
    end
    finishTest("allChannels", errorsBefore);
  endtask

  task automatic backPressureTest();
    int errorsBefore;
    errorsBefore = errCount;
    setupScan(1'b1, 6'd21, 1'b1, 10'd100, 10'd140, 10'd20, 3'd1, 3'd0, 1'b0);
    fork
      runScan(0);
      holdFull(3);
    join
    compareStream("backPressure");
    finishTest("backPressure", errorsBefore);
  endtask

  task automatic unmaskAllTest();
    int errorsBefore;
    errorsBefore = errCount;
    setupScan(1'b1, 6'd40, 1'b0, 10'd50, 10'd50, 10'd1, 3'd3, 3'd0, 1'b1);
    runScan(0);
    compareStream("unmaskAll");
    checkValue("unmaskAll load count", 192'(3), 192'(loadMasks.size()));
    for (int i = 0; i < loadMasks.size(); i++) begin
      checkValue($sformatf("unmaskAll load %0d mask", i), (i == 2) ? '1 : 192'd0,
                 loadMasks[i]);
      checkValue("unmaskAll ctestChannels", 192'(64'd1 << 40), 192'(loadCtest[i]));
    end
    finishTest("unmaskAll", errorsBefore);
  endtask

  task automatic doneHandshakeTest();
    int errorsBefore;
    errorsBefore = errCount;
    setupScan(1'b1, 6'd63, 1'b1, 10'd1000, 10'd1010, 10'd10, 3'd1, 3'd0, 1'b0);
    runScan(20);
    compareStream("doneHandshake first scan");
    clearRecords();
    runScan(0);                    // Fresh scan after the acknowledge
    compareStream("doneHandshake second scan");
    finishTest("doneHandshake", errorsBefore);
  endtask

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  initial begin
    #(clkPeriod * (resetCycles + totalSteps * stepBudget));
    $display("Timeout: the scans did not complete in the expected time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    lfsr           = 16'd7874;
    fullSeen       = 1'b0;
    errCount       = 0;
    testsRun       = 0;
    testsFailed    = 0;
    reset_n        = 1'b0;
    testStart      = 1'b0;
    singleChannel  = 1'b1;
    testChannel    = '0;
    ctestInject    = 1'b0;
    startDac       = '0;
    endDac         = '0;
    dacStep        = 10'd1;
    asicNumber     = 3'd1;
    testAsicNumber = '0;
    unmaskAll      = 1'b0;
    configDone     = 1'b0;
    trigger        = 1'b0;
    usbFifoFull    = 1'b0;
    transmitDone   = 1'b0;
    repeat (resetCycles) @(posedge Clk);
    reset_n <= 1'b1;

    singleScanTest();
    chainMaskTest();
    allChannelTest();
    backPressureTest();
    unmaskAllTest();
    doneHandshakeTest();

    $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
    if (errCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
